// ==== build.f ====
+incdir+logic
logic/cpu_pkg.sv
logic/alu.sv
logic/regfile.sv
logic/inst_decoder.sv
logic/cpu_control.sv
logic/cpu_top.sv
dv/cpu_properties.sv
dv/trace_checker.sv
dv/tb_cpu_top.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --assert
TOP       := tb_cpu_top
FILELIST  := build.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SIM_ARGS  := +verilator+error+limit+100
FAIL_MSG  := SIMULATION FAILED
PASS_MSG  := SIMULATION PASSED
SOURCES   := $(wildcard logic/*.sv logic/*.svh dv/*.sv)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/tb_cpu_top.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defs.svh"

module tb_cpu_top;

    localparam int NROWS = 39;
    localparam int LIMIT = 5 * NROWS + 20;
    localparam logic [31:0] SEED = 32'h6ab7;

    logic        clk;
    logic        reset;
    logic [31:0] inst_sram_rdata;
    logic [31:0] data_sram_rdata;
    wire  [31:0] inst_sram_addr;
    wire         inst_sram_we;
    wire  [31:0] inst_sram_wdata;
    wire  [31:0] data_sram_addr;
    wire         data_sram_we;
    wire  [31:0] data_sram_wdata;
    wire  [31:0] debug_wb_pc;
    wire  [3:0]  debug_wb_rf_we;
    wire  [4:0]  debug_wb_rf_wnum;
    wire  [31:0] debug_wb_rf_wdata;

    logic [31:0] prog [NROWS];
    logic        row_wb [NROWS];
    logic [4:0]  row_rd [NROWS];
    logic [31:0] row_val [NROWS];
    logic [31:0] exp_pc [NROWS];
    logic [4:0]  exp_num [NROWS];
    logic [31:0] exp_val [NROWS];
    int          exp_count;
    int          row_count;
    int          cycles;
    int          violations;
    logic        done;
    int          pass_count;
    int          fail_count;
    logic [31:0] imem [logic [31:0]];
    logic [31:0] dmem [logic [31:0]];
    logic [31:0] iaddr_q;
    logic [31:0] daddr_q;

    cpu_top dut0 (
        .clk(clk), .reset(reset),
        .inst_sram_addr(inst_sram_addr), .inst_sram_we(inst_sram_we),
        .inst_sram_wdata(inst_sram_wdata), .inst_sram_rdata(inst_sram_rdata),
        .data_sram_addr(data_sram_addr), .data_sram_we(data_sram_we),
        .data_sram_wdata(data_sram_wdata), .data_sram_rdata(data_sram_rdata),
        .debug_wb_pc(debug_wb_pc), .debug_wb_rf_we(debug_wb_rf_we),
        .debug_wb_rf_wnum(debug_wb_rf_wnum), .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

    trace_checker #(.MAX_ENTRIES(NROWS)) trace_check0 (
        .clk(clk), .reset(reset),
        .debug_wb_pc(debug_wb_pc), .debug_wb_rf_we(debug_wb_rf_we),
        .debug_wb_rf_wnum(debug_wb_rf_wnum), .debug_wb_rf_wdata(debug_wb_rf_wdata),
        .exp_pc(exp_pc), .exp_num(exp_num), .exp_val(exp_val), .exp_count(exp_count),
        .done(done), .pass_count(pass_count), .fail_count(fail_count)
    );

    bind cpu_control cpu_properties props0 (
        .clk(clk), .reset(reset), .state(state), .data_sram_we(data_sram_we),
        .rf_we(rf_we), .inst_sram_we(tb_cpu_top.dut0.inst_sram_we),
        .inst_sram_wdata(tb_cpu_top.dut0.inst_sram_wdata)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // untouched data words depend on the full word address.
    function automatic logic [31:0] data_fill(input logic [31:0] addr);
        return lcg_next(lcg_next(SEED ^ addr));
    endfunction

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        if ($isunknown(addr) || !imem.exists(addr))
            return 32'h0;
        return imem[addr];
    endfunction

    function automatic logic [31:0] load_word(input logic [31:0] addr);
        logic [31:0] key;
        key = {addr[31:2], 2'b00};
        if ($isunknown(addr))
            return 32'h0;
        if (dmem.exists(key))
            return dmem[key];
        return data_fill(key);
    endfunction

    function automatic logic [31:0] three_reg(input logic [16:0] op, input logic [4:0] rd,
                                              input logic [4:0] rj, input logic [4:0] rk);
        cpu_pkg::inst_word_u w;
        w.fmt_3r.opcode = op;
        w.fmt_3r.rk = rk;
        w.fmt_3r.rj = rj;
        w.fmt_3r.rd = rd;
        return w;
    endfunction

    function automatic logic [31:0] imm12_form(input logic [9:0] op, input logic [4:0] rd,
                                               input logic [4:0] rj, input logic [11:0] si12);
        cpu_pkg::inst_word_u w;
        w.fmt_2ri12.opcode = op;
        w.fmt_2ri12.si12 = si12;
        w.fmt_2ri12.rj = rj;
        w.fmt_2ri12.rd = rd;
        return w;
    endfunction

    // offsets are in words.
    function automatic logic [31:0] offs16_form(input logic [5:0] op, input logic [4:0] rd,
                                                input logic [4:0] rj, input logic [15:0] offs);
        cpu_pkg::inst_word_u w;
        w.fmt_2ri16.opcode = op;
        w.fmt_2ri16.offs16 = offs;
        w.fmt_2ri16.rj = rj;
        w.fmt_2ri16.rd = rd;
        return w;
    endfunction

    function automatic logic [31:0] offs26_form(input logic [5:0] op, input logic [25:0] offs);
        cpu_pkg::inst_word_u w;
        w.fmt_2ri16.opcode = op;
        w.fmt_2ri16.offs16 = offs[15:0];
        w.fmt_2ri16.rd = offs[20:16];
        w.fmt_2ri16.rj = offs[25:21];
        return w;
    endfunction

    function automatic logic [31:0] upper_imm(input logic [4:0] rd, input logic [19:0] si20);
        cpu_pkg::inst_word_u w;
        w.fmt_1ri20.opcode = `CPU_OP_LU12I_W;
        w.fmt_1ri20.si20 = si20;
        w.fmt_1ri20.rd = rd;
        return w;
    endfunction

    task automatic put_row(input logic [31:0] word, input logic wb, input logic [4:0] rd,
                           input logic [31:0] value);
        prog[row_count] = word;
        row_wb[row_count] = wb;
        row_rd[row_count] = rd;
        row_val[row_count] = value;
        row_count++;
    endtask

    task automatic expect_write(input logic [31:0] word, input logic [4:0] rd,
                                input logic [31:0] value);
        put_row(word, 1'b1, rd, value);
    endtask

    task automatic no_write(input logic [31:0] word);
        put_row(word, 1'b0, 5'd0, 32'h0);
    endtask

    // row i sits at CPU_RESET_PC + 4 * i.
    task automatic build_program();
        expect_write(upper_imm(5'd1, 20'h12345), 5'd1, 32'h1234_5000);
        expect_write(imm12_form(`CPU_OP_ADDI_W, 5'd1, 5'd1, 12'h678), 5'd1, 32'h1234_5678);
        expect_write(imm12_form(`CPU_OP_ADDI_W, 5'd2, 5'd0, 12'hfff), 5'd2, 32'hffff_ffff);
        expect_write(imm12_form(`CPU_OP_ADDI_W, 5'd3, 5'd0, 12'h7ff), 5'd3, 32'h0000_07ff);
        expect_write(three_reg(`CPU_OP_ADD_W, 5'd4, 5'd1, 5'd3), 5'd4, 32'h1234_5678 + 32'h7ff);
        expect_write(three_reg(`CPU_OP_SUB_W, 5'd5, 5'd3, 5'd1), 5'd5, 32'h7ff - 32'h1234_5678);
        expect_write(three_reg(`CPU_OP_SLT, 5'd6, 5'd2, 5'd3), 5'd6, 32'd1);
        expect_write(three_reg(`CPU_OP_SLTU, 5'd7, 5'd2, 5'd3), 5'd7, 32'd0);
        expect_write(three_reg(`CPU_OP_NOR, 5'd8, 5'd1, 5'd3), 5'd8, ~(32'h1234_5678 | 32'h7ff));
        expect_write(three_reg(`CPU_OP_AND, 5'd9, 5'd1, 5'd2), 5'd9, 32'h1234_5678);
        expect_write(three_reg(`CPU_OP_OR, 5'd10, 5'd1, 5'd3), 5'd10, 32'h1234_5678 | 32'h7ff);
        expect_write(three_reg(`CPU_OP_XOR, 5'd11, 5'd1, 5'd2), 5'd11, ~32'h1234_5678);
        expect_write(three_reg(`CPU_OP_SLLI_W, 5'd12, 5'd2, 5'd31), 5'd12, 32'h8000_0000);
        expect_write(three_reg(`CPU_OP_SRLI_W, 5'd13, 5'd2, 5'd31), 5'd13, 32'h1);
        expect_write(three_reg(`CPU_OP_SRAI_W, 5'd14, 5'd12, 5'd31), 5'd14, 32'hffff_ffff);
        expect_write(three_reg(`CPU_OP_SRAI_W, 5'd15, 5'd1, 5'd4), 5'd15, 32'h0123_4567);
        expect_write(imm12_form(`CPU_OP_ADDI_W, 5'd16, 5'd0, 12'h100), 5'd16, 32'h100);
        no_write(imm12_form(`CPU_OP_ST_W, 5'd1, 5'd16, 12'h008));
        expect_write(imm12_form(`CPU_OP_LD_W, 5'd17, 5'd16, 12'h008), 5'd17, 32'h1234_5678);
        expect_write(imm12_form(`CPU_OP_LD_W, 5'd18, 5'd16, 12'h040), 5'd18, data_fill(32'h140));
        no_write(imm12_form(`CPU_OP_ADDI_W, 5'd0, 5'd0, 12'h005));
        expect_write(three_reg(`CPU_OP_ADD_W, 5'd19, 5'd0, 5'd3), 5'd19, 32'h7ff);
        // rows 22 to 33 exercise the branches.
        no_write(offs16_form(`CPU_OP_BEQ, 5'd9, 5'd1, 16'd2));
        no_write(imm12_form(`CPU_OP_ADDI_W, 5'd20, 5'd0, 12'h001));
        no_write(offs16_form(`CPU_OP_BEQ, 5'd2, 5'd1, 16'd2));
        expect_write(imm12_form(`CPU_OP_ADDI_W, 5'd20, 5'd0, 12'h002), 5'd20, 32'd2);
        no_write(offs16_form(`CPU_OP_BNE, 5'd2, 5'd1, 16'd2));
        no_write(imm12_form(`CPU_OP_ADDI_W, 5'd21, 5'd0, 12'h003));
        no_write(offs16_form(`CPU_OP_BNE, 5'd9, 5'd1, 16'd2));
        expect_write(imm12_form(`CPU_OP_ADDI_W, 5'd21, 5'd0, 12'h004), 5'd21, 32'd4);
        no_write(offs26_form(`CPU_OP_B, 26'd2));
        no_write(imm12_form(`CPU_OP_ADDI_W, 5'd22, 5'd0, 12'h005));
        expect_write(offs26_form(`CPU_OP_BL, 26'd2), 5'd1, `CPU_RESET_PC + 32'd132);
        no_write(imm12_form(`CPU_OP_ADDI_W, 5'd23, 5'd0, 12'h006));
        expect_write(upper_imm(5'd24, 20'h1c000), 5'd24, `CPU_RESET_PC);
        // jirl lands on row 37.
        expect_write(offs16_form(`CPU_OP_JIRL, 5'd25, 5'd24, 16'd37), 5'd25,
                     `CPU_RESET_PC + 32'd144);
        no_write(imm12_form(`CPU_OP_ADDI_W, 5'd26, 5'd0, 12'h007));
        expect_write(imm12_form(`CPU_OP_ADDI_W, 5'd26, 5'd0, 12'h800), 5'd26, 32'hffff_f800);
        no_write(offs26_form(`CPU_OP_B, 26'd0));
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // read data follows the address of the previous cycle.
    always @(posedge clk) begin
        iaddr_q <= inst_sram_addr;
        daddr_q <= data_sram_addr;
        if (data_sram_we === 1'b1)
            dmem[{data_sram_addr[31:2], 2'b00}] = data_sram_wdata;
    end

    always @(negedge clk) begin
        inst_sram_rdata <= fetch_word(iaddr_q);
        data_sram_rdata <= load_word(daddr_q);
    end

    initial begin
        reset = 1'b1;
        inst_sram_rdata = 32'h0;
        data_sram_rdata = 32'h0;
        row_count = 0;
        exp_count = 0;
        build_program();
        for (int i = 0; i < NROWS; i++) begin
            imem[`CPU_RESET_PC + 32'(4 * i)] = prog[i];
            if (row_wb[i]) begin
                exp_pc[exp_count] = `CPU_RESET_PC + 32'(4 * i);
                exp_num[exp_count] = row_rd[i];
                exp_val[exp_count] = row_val[i];
                exp_count++;
            end
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        cycles = 0;
        while (!done && cycles < LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!done)
            $display("error: timeout after %0d cycles, only %0d of %0d write-backs seen",
                     cycles, pass_count + fail_count, exp_count);
        violations = dut0.u_control.props0.violations;
        if (violations != 0)
            $display("error: %0d assertion failures in cpu_control", violations);
        $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (done && fail_count == 0 && violations == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/trace_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module trace_checker #(
    parameter int MAX_ENTRIES = 64
) (
    input  wire         clk,
    input  wire         reset,
    input  wire  [31:0] debug_wb_pc,
    input  wire  [3:0]  debug_wb_rf_we,
    input  wire  [4:0]  debug_wb_rf_wnum,
    input  wire  [31:0] debug_wb_rf_wdata,
    input  logic [31:0] exp_pc [MAX_ENTRIES],
    input  logic [4:0]  exp_num [MAX_ENTRIES],
    input  logic [31:0] exp_val [MAX_ENTRIES],
    input  int          exp_count,
    output logic        done,
    output int          pass_count,
    output int          fail_count
);

    int   idx = 0;
    int   passes = 0;
    int   fails = 0;
    logic ok;

    assign done       = idx >= exp_count;
    assign pass_count = passes;
    assign fail_count = fails;

    // trace is stable since the falling edge.
    always @(posedge clk) begin
        if (!reset && debug_wb_rf_we != 4'h0) begin
            if (idx >= exp_count) begin
                $display("error at time %0t: write-back to r%0d with no expected entry left",
                         $time, debug_wb_rf_wnum);
                fails <= fails + 1;
            end else begin
                ok = 1'b1;
                if (debug_wb_rf_we !== 4'hf) begin
                    $display("mismatch at time %0t: debug_wb_rf_we expected %h, actual %h",
                             $time, 4'hf, debug_wb_rf_we);
                    ok = 1'b0;
                end
                if (debug_wb_pc !== exp_pc[idx]) begin
                    $display("mismatch at time %0t: debug_wb_pc expected %h, actual %h",
                             $time, exp_pc[idx], debug_wb_pc);
                    ok = 1'b0;
                end
                if (debug_wb_rf_wnum !== exp_num[idx]) begin
                    $display("mismatch at time %0t: debug_wb_rf_wnum expected %0d, actual %0d",
                             $time, exp_num[idx], debug_wb_rf_wnum);
                    ok = 1'b0;
                end
                if (debug_wb_rf_wdata !== exp_val[idx]) begin
                    $display("mismatch at time %0t: debug_wb_rf_wdata expected %h, actual %h",
                             $time, exp_val[idx], debug_wb_rf_wdata);
                    ok = 1'b0;
                end
                if (ok) begin
                    $display("test %0d: pc %h r%0d = %h ok",
                             idx, exp_pc[idx], exp_num[idx], exp_val[idx]);
                    passes <= passes + 1;
                end else begin
                    $display("test %0d: pc %h failed", idx, exp_pc[idx]);
                    fails <= fails + 1;
                end
                idx <= idx + 1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/cpu_properties.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_properties (
    input wire                      clk,
    input wire                      reset,
    input wire cpu_pkg::cpu_state_e state,
    input wire                      data_sram_we,
    input wire                      rf_we,
    input wire                      inst_sram_we,
    input wire [31:0]               inst_sram_wdata
);

    int unsigned violations = 0;

    // store strobe lasts a single cycle.
    data_we_single: assert property (@(posedge clk) disable iff (reset)
        data_sram_we |=> !data_sram_we)
        else begin
            $error("data_sram_we high for two cycles in a row");
            violations = violations + 1;
        end

    rf_we_in_wb: assert property (@(posedge clk) disable iff (reset)
        rf_we |-> state == cpu_pkg::wb_s)
        else begin
            $error("rf_we high outside wb_s");
            violations = violations + 1;
        end

    inst_we_low: assert property (@(posedge clk) disable iff (reset)
        !inst_sram_we)
        else begin
            $error("inst_sram_we went high");
            violations = violations + 1;
        end

    inst_wdata_zero: assert property (@(posedge clk) disable iff (reset)
        inst_sram_wdata == 32'h0)
        else begin
            $error("inst_sram_wdata left its idle value");
            violations = violations + 1;
        end

    state_legal: assert property (@(posedge clk) disable iff (reset)
        state inside {cpu_pkg::if_s, cpu_pkg::id_s, cpu_pkg::exe_s,
                      cpu_pkg::mem_s, cpu_pkg::wb_s})
        else begin
            $error("state register holds an illegal value");
            violations = violations + 1;
        end

endmodule

`default_nettype wire

// ==== logic/cpu_top.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defs.svh"

module cpu_top (
    input  wire                    clk,
    input  wire                    reset,
    output wire [`CPU_XLEN-1:0]    inst_sram_addr,
    output wire                    inst_sram_we,
    output wire [`CPU_XLEN-1:0]    inst_sram_wdata,
    input  wire [`CPU_XLEN-1:0]    inst_sram_rdata,
    output wire [`CPU_XLEN-1:0]    data_sram_addr,
    output wire                    data_sram_we,
    output wire [`CPU_XLEN-1:0]    data_sram_wdata,
    input  wire [`CPU_XLEN-1:0]    data_sram_rdata,
    output wire [`CPU_XLEN-1:0]    debug_wb_pc,
    output wire [3:0]              debug_wb_rf_we,
    output wire [4:0]              debug_wb_rf_wnum,
    output wire [`CPU_XLEN-1:0]    debug_wb_rf_wdata
);

    wire cpu_pkg::inst_word_u inst;
    wire cpu_pkg::alu_op_e    alu_op;
    wire                      src1_is_pc;
    wire                      src2_is_imm;
    wire [`CPU_XLEN-1:0]      imm;
    wire                      gr_we;
    wire                      mem_we;
    wire                      res_from_mem;
    wire [4:0]                dest;
    wire [4:0]                rf_raddr1;
    wire [4:0]                rf_raddr2;
    wire                      is_branch_cond;
    wire                      is_branch_ne;
    wire                      is_jump;
    wire                      is_jirl;
    wire [`CPU_XLEN-1:0]      br_offs;
    wire [`CPU_XLEN-1:0]      rf_rdata1;
    wire [`CPU_XLEN-1:0]      rf_rdata2;
    wire                      rf_we;
    wire [4:0]                rf_waddr;
    wire [`CPU_XLEN-1:0]      rf_wdata;
    wire [`CPU_XLEN-1:0]      alu_src1;
    wire [`CPU_XLEN-1:0]      alu_src2;
    wire [`CPU_XLEN-1:0]      alu_result;

    // instruction memory is read only.
    assign inst_sram_we    = 1'b0;
    assign inst_sram_wdata = '0;

    cpu_control u_control (
        .clk(clk), .reset(reset),
        .inst_sram_rdata(inst_sram_rdata), .data_sram_rdata(data_sram_rdata),
        .rf_rdata1(rf_rdata1), .rf_rdata2(rf_rdata2), .alu_result(alu_result),
        .src1_is_pc(src1_is_pc), .src2_is_imm(src2_is_imm), .imm(imm),
        .gr_we(gr_we), .mem_we(mem_we), .res_from_mem(res_from_mem), .dest(dest),
        .is_branch_cond(is_branch_cond), .is_branch_ne(is_branch_ne),
        .is_jump(is_jump), .is_jirl(is_jirl), .br_offs(br_offs),
        .inst(inst), .inst_sram_addr(inst_sram_addr),
        .data_sram_addr(data_sram_addr), .data_sram_we(data_sram_we),
        .data_sram_wdata(data_sram_wdata),
        .alu_src1(alu_src1), .alu_src2(alu_src2),
        .rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
        .debug_wb_pc(debug_wb_pc), .debug_wb_rf_we(debug_wb_rf_we),
        .debug_wb_rf_wnum(debug_wb_rf_wnum), .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

    inst_decoder u_decoder (
        .inst(inst), .alu_op(alu_op), .src1_is_pc(src1_is_pc),
        .src2_is_imm(src2_is_imm), .imm(imm), .gr_we(gr_we), .mem_we(mem_we),
        .res_from_mem(res_from_mem), .dest(dest),
        .rf_raddr1(rf_raddr1), .rf_raddr2(rf_raddr2),
        .is_branch_cond(is_branch_cond), .is_branch_ne(is_branch_ne),
        .is_jump(is_jump), .is_jirl(is_jirl), .br_offs(br_offs)
    );

    regfile u_regfile (
        .clk(clk), .raddr1(rf_raddr1), .raddr2(rf_raddr2),
        .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata),
        .rdata1(rf_rdata1), .rdata2(rf_rdata2)
    );

    alu u_alu (
        .alu_op(alu_op), .alu_src1(alu_src1), .alu_src2(alu_src2),
        .alu_result(alu_result)
    );

endmodule

`default_nettype wire

// ==== logic/cpu_control.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defs.svh"

module cpu_control (
    input  wire                     clk,
    input  wire                     reset,
    input  wire [`CPU_XLEN-1:0]     inst_sram_rdata,
    input  wire [`CPU_XLEN-1:0]     data_sram_rdata,
    input  wire [`CPU_XLEN-1:0]     rf_rdata1,
    input  wire [`CPU_XLEN-1:0]     rf_rdata2,
    input  wire [`CPU_XLEN-1:0]     alu_result,
    input  wire                     src1_is_pc,
    input  wire                     src2_is_imm,
    input  wire [`CPU_XLEN-1:0]     imm,
    input  wire                     gr_we,
    input  wire                     mem_we,
    input  wire                     res_from_mem,
    input  wire [4:0]               dest,
    input  wire                     is_branch_cond,
    input  wire                     is_branch_ne,
    input  wire                     is_jump,
    input  wire                     is_jirl,
    input  wire [`CPU_XLEN-1:0]     br_offs,
    output cpu_pkg::inst_word_u     inst,
    output logic [`CPU_XLEN-1:0]    inst_sram_addr,
    output logic [`CPU_XLEN-1:0]    data_sram_addr,
    output logic                    data_sram_we,
    output logic [`CPU_XLEN-1:0]    data_sram_wdata,
    output logic [`CPU_XLEN-1:0]    alu_src1,
    output logic [`CPU_XLEN-1:0]    alu_src2,
    output logic                    rf_we,
    output logic [4:0]              rf_waddr,
    output logic [`CPU_XLEN-1:0]    rf_wdata,
    output logic [`CPU_XLEN-1:0]    debug_wb_pc,
    output logic [3:0]              debug_wb_rf_we,
    output logic [4:0]              debug_wb_rf_wnum,
    output logic [`CPU_XLEN-1:0]    debug_wb_rf_wdata
);

    cpu_pkg::cpu_state_e state;
    cpu_pkg::cpu_state_e state_nxt;
    logic [`CPU_XLEN-1:0] pc;
    logic [`CPU_XLEN-1:0] pc_nxt;
    logic [`CPU_XLEN-1:0] seq_pc;
    logic [`CPU_XLEN-1:0] br_target;
    logic [`CPU_XLEN-1:0] inst_r;
    logic [`CPU_XLEN-1:0] cur_pc;
    logic [`CPU_XLEN-1:0] rkd_r;
    logic [`CPU_XLEN-1:0] alu_res_r;
    logic                 operands_eq;
    logic                 br_taken;
    logic                 instr_done;

    always_comb begin
        unique case (state)
            cpu_pkg::if_s:  state_nxt = cpu_pkg::id_s;
            // no write and no store means a branch.
            cpu_pkg::id_s:  state_nxt = (gr_we || mem_we) ? cpu_pkg::exe_s : cpu_pkg::if_s;
            cpu_pkg::exe_s: state_nxt = (mem_we || res_from_mem) ? cpu_pkg::mem_s
                                                                  : cpu_pkg::wb_s;
            cpu_pkg::mem_s: state_nxt = res_from_mem ? cpu_pkg::wb_s : cpu_pkg::if_s;
            default:        state_nxt = cpu_pkg::if_s;
        endcase
    end

    // the fetched word is valid only during id.
    assign inst = (state == cpu_pkg::id_s) ? inst_sram_rdata : inst_r;

    assign operands_eq = rf_rdata1 == rf_rdata2;
    assign br_taken    = is_jump | (is_branch_cond & (is_branch_ne ^ operands_eq));
    assign br_target   = (is_jirl ? rf_rdata1 : pc) + br_offs;
    assign seq_pc      = pc + `CPU_XLEN'd4;
    assign instr_done  = (state != cpu_pkg::if_s) && (state_nxt == cpu_pkg::if_s);

    // jumps already moved pc at the end of id.
    always_comb begin
        pc_nxt = pc;
        if (state == cpu_pkg::id_s && br_taken)
            pc_nxt = br_target;
        else if (instr_done && !is_jump)
            pc_nxt = seq_pc;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cpu_pkg::if_s;
            pc    <= `CPU_RESET_PC;
        end else begin
            state <= state_nxt;
            pc    <= pc_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (state == cpu_pkg::id_s) begin
            inst_r   <= inst_sram_rdata;
            cur_pc   <= pc;
            alu_src1 <= src1_is_pc ? pc : rf_rdata1;
            alu_src2 <= src2_is_imm ? imm : rf_rdata2;
            rkd_r    <= rf_rdata2;
        end
        if (state == cpu_pkg::exe_s) begin
            alu_res_r <= alu_result;
        end
    end

    assign inst_sram_addr  = pc;
    assign data_sram_addr  = alu_res_r;
    assign data_sram_we    = (state == cpu_pkg::mem_s) && mem_we;
    assign data_sram_wdata = rkd_r;

    // load data arrives in wb.
    assign rf_we    = (state == cpu_pkg::wb_s) && gr_we && (dest != 5'd0);
    assign rf_waddr = dest;
    assign rf_wdata = res_from_mem ? data_sram_rdata : alu_res_r;

    assign debug_wb_pc       = cur_pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = dest;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule

`default_nettype wire

// ==== logic/inst_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defs.svh"

module inst_decoder (
    input  wire cpu_pkg::inst_word_u inst,
    output cpu_pkg::alu_op_e         alu_op,
    output logic                     src1_is_pc,
    output logic                     src2_is_imm,
    output logic [`CPU_XLEN-1:0]     imm,
    output logic                     gr_we,
    output logic                     mem_we,
    output logic                     res_from_mem,
    output logic [4:0]               dest,
    output logic [4:0]               rf_raddr1,
    output logic [4:0]               rf_raddr2,
    output logic                     is_branch_cond,
    output logic                     is_branch_ne,
    output logic                     is_jump,
    output logic                     is_jirl,
    output logic [`CPU_XLEN-1:0]     br_offs
);

    logic inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic inst_nor, inst_and, inst_or, inst_xor;
    logic inst_slli_w, inst_srli_w, inst_srai_w;
    logic inst_addi_w, inst_ld_w, inst_st_w, inst_lu12i_w;
    logic inst_jirl, inst_b, inst_bl, inst_beq, inst_bne;
    logic is_shift;
    logic [11:0] si12;
    logic [15:0] offs16;

    assign inst_add_w   = inst.fmt_3r.opcode == `CPU_OP_ADD_W;
    assign inst_sub_w   = inst.fmt_3r.opcode == `CPU_OP_SUB_W;
    assign inst_slt     = inst.fmt_3r.opcode == `CPU_OP_SLT;
    assign inst_sltu    = inst.fmt_3r.opcode == `CPU_OP_SLTU;
    assign inst_nor     = inst.fmt_3r.opcode == `CPU_OP_NOR;
    assign inst_and     = inst.fmt_3r.opcode == `CPU_OP_AND;
    assign inst_or      = inst.fmt_3r.opcode == `CPU_OP_OR;
    assign inst_xor     = inst.fmt_3r.opcode == `CPU_OP_XOR;
    assign inst_slli_w  = inst.fmt_3r.opcode == `CPU_OP_SLLI_W;
    assign inst_srli_w  = inst.fmt_3r.opcode == `CPU_OP_SRLI_W;
    assign inst_srai_w  = inst.fmt_3r.opcode == `CPU_OP_SRAI_W;
    assign inst_addi_w  = inst.fmt_2ri12.opcode == `CPU_OP_ADDI_W;
    assign inst_ld_w    = inst.fmt_2ri12.opcode == `CPU_OP_LD_W;
    assign inst_st_w    = inst.fmt_2ri12.opcode == `CPU_OP_ST_W;
    assign inst_jirl    = inst.fmt_2ri16.opcode == `CPU_OP_JIRL;
    assign inst_b       = inst.fmt_2ri16.opcode == `CPU_OP_B;
    assign inst_bl      = inst.fmt_2ri16.opcode == `CPU_OP_BL;
    assign inst_beq     = inst.fmt_2ri16.opcode == `CPU_OP_BEQ;
    assign inst_bne     = inst.fmt_2ri16.opcode == `CPU_OP_BNE;
    assign inst_lu12i_w = inst.fmt_1ri20.opcode == `CPU_OP_LU12I_W;

    assign is_shift = inst_slli_w | inst_srli_w | inst_srai_w;
    assign si12     = inst.fmt_2ri12.si12;
    assign offs16   = inst.fmt_2ri16.offs16;

    always_comb begin
        if (inst_sub_w)        alu_op = cpu_pkg::alu_sub;
        else if (inst_slt)     alu_op = cpu_pkg::alu_slt;
        else if (inst_sltu)    alu_op = cpu_pkg::alu_sltu;
        else if (inst_and)     alu_op = cpu_pkg::alu_and;
        else if (inst_nor)     alu_op = cpu_pkg::alu_nor;
        else if (inst_or)      alu_op = cpu_pkg::alu_or;
        else if (inst_xor)     alu_op = cpu_pkg::alu_xor;
        else if (inst_slli_w)  alu_op = cpu_pkg::alu_sll;
        else if (inst_srli_w)  alu_op = cpu_pkg::alu_srl;
        else if (inst_srai_w)  alu_op = cpu_pkg::alu_sra;
        else if (inst_lu12i_w) alu_op = cpu_pkg::alu_lui;
        else                   alu_op = cpu_pkg::alu_add;
    end

    // link value pc + 4 goes through the adder.
    always_comb begin
        if (inst_jirl | inst_bl)
            imm = `CPU_XLEN'd4;
        else if (inst_lu12i_w)
            imm = {inst.fmt_1ri20.si20, 12'b0};
        else if (is_shift)
            imm = {{(`CPU_XLEN-5){1'b0}}, inst.fmt_3r.rk};
        else
            imm = {{(`CPU_XLEN-12){si12[11]}}, si12};
    end

    // offs26 is {rj, rd, offs16} for b and bl.
    assign br_offs = (inst_b | inst_bl) ?
        {{4{inst.fmt_2ri16.rj[4]}}, inst.fmt_2ri16.rj, inst.fmt_2ri16.rd, offs16, 2'b0} :
        {{14{offs16[15]}}, offs16, 2'b0};

    assign src1_is_pc   = inst_jirl | inst_bl;
    assign src2_is_imm  = is_shift | inst_addi_w | inst_ld_w | inst_st_w | inst_lu12i_w
                        | inst_jirl | inst_bl;
    assign gr_we        = inst_add_w | inst_sub_w | inst_slt | inst_sltu | inst_nor
                        | inst_and | inst_or | inst_xor | is_shift | inst_addi_w
                        | inst_ld_w | inst_lu12i_w | inst_jirl | inst_bl;
    assign mem_we       = inst_st_w;
    assign res_from_mem = inst_ld_w;
    assign dest         = inst_bl ? 5'd1 : inst.fmt_3r.rd;
    assign rf_raddr1    = inst.fmt_3r.rj;
    assign rf_raddr2    = (inst_beq | inst_bne | inst_st_w) ? inst.fmt_3r.rd : inst.fmt_3r.rk;

    assign is_branch_cond = inst_beq | inst_bne;
    assign is_branch_ne   = inst_bne;
    assign is_jump        = inst_b | inst_bl | inst_jirl;
    assign is_jirl        = inst_jirl;

endmodule

`default_nettype wire

// ==== logic/regfile.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defs.svh"

module regfile (
    input  wire                   clk,
    input  wire [4:0]             raddr1,
    input  wire [4:0]             raddr2,
    input  wire                   we,
    input  wire [4:0]             waddr,
    input  wire [`CPU_XLEN-1:0]   wdata,
    output logic [`CPU_XLEN-1:0]  rdata1,
    output logic [`CPU_XLEN-1:0]  rdata2
);

    logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];

    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 reads as zero.
    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// ==== logic/alu.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defs.svh"

module alu (
    input  wire cpu_pkg::alu_op_e    alu_op,
    input  wire [`CPU_XLEN-1:0]      alu_src1,
    input  wire [`CPU_XLEN-1:0]      alu_src2,
    output logic [`CPU_XLEN-1:0]     alu_result
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = alu_src2[4:0];
    assign lt_signed   = $signed(alu_src1) < $signed(alu_src2);
    assign lt_unsigned = alu_src1 < alu_src2;

    always_comb begin
        unique case (alu_op)
            cpu_pkg::alu_add:  alu_result = alu_src1 + alu_src2;
            cpu_pkg::alu_sub:  alu_result = alu_src1 - alu_src2;
            cpu_pkg::alu_slt:  alu_result = {{(`CPU_XLEN-1){1'b0}}, lt_signed};
            cpu_pkg::alu_sltu: alu_result = {{(`CPU_XLEN-1){1'b0}}, lt_unsigned};
            cpu_pkg::alu_and:  alu_result = alu_src1 & alu_src2;
            cpu_pkg::alu_nor:  alu_result = ~(alu_src1 | alu_src2);
            cpu_pkg::alu_or:   alu_result = alu_src1 | alu_src2;
            cpu_pkg::alu_xor:  alu_result = alu_src1 ^ alu_src2;
            cpu_pkg::alu_sll:  alu_result = alu_src1 << shamt;
            cpu_pkg::alu_srl:  alu_result = alu_src1 >> shamt;
            // arithmetic shift keeps the sign.
            cpu_pkg::alu_sra:  alu_result = $signed(alu_src1) >>> shamt;
            // upper immediate already shifted by the decoder.
            cpu_pkg::alu_lui:  alu_result = alu_src2;
            default:           alu_result = alu_src1 + alu_src2;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    typedef struct packed {
        logic [16:0] opcode;
        logic [4:0]  rk;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_3r_t;

    typedef struct packed {
        logic [9:0]  opcode;
        logic [11:0] si12;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_2ri12_t;

    // b and bl keep the upper offset bits in the rj and rd fields.
    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] offs16;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_2ri16_t;

    typedef struct packed {
        logic [6:0]  opcode;
        logic [19:0] si20;
        logic [4:0]  rd;
    } fmt_1ri20_t;

    typedef union packed {
        fmt_3r_t    fmt_3r;
        fmt_2ri12_t fmt_2ri12;
        fmt_2ri16_t fmt_2ri16;
        fmt_1ri20_t fmt_1ri20;
    } inst_word_u;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu, alu_and, alu_nor,
        alu_or, alu_xor, alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_e;

    typedef enum logic [2:0] {
        if_s, id_s, exe_s, mem_s, wb_s
    } cpu_state_e;

endpackage

`default_nettype wire

// ==== logic/cpu_defs.svh ====
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// first fetch address after reset.
`define CPU_RESET_PC    32'h1c00_0000
`define CPU_XLEN        32
`define CPU_NREGS       32

// 3r format keeps the opcode in inst[31:15].
`define CPU_OP_ADD_W    17'h00020
`define CPU_OP_SUB_W    17'h00022
`define CPU_OP_SLT      17'h00024
`define CPU_OP_SLTU     17'h00025
`define CPU_OP_NOR      17'h00028
`define CPU_OP_AND      17'h00029
`define CPU_OP_OR       17'h0002a
`define CPU_OP_XOR      17'h0002b
`define CPU_OP_SLLI_W   17'h00081
`define CPU_OP_SRLI_W   17'h00089
`define CPU_OP_SRAI_W   17'h00091

// 2ri12 format keeps the opcode in inst[31:22].
`define CPU_OP_ADDI_W   10'h00a
`define CPU_OP_LD_W     10'h0a2
`define CPU_OP_ST_W     10'h0a6

// 2ri16 format keeps the opcode in inst[31:26].
`define CPU_OP_JIRL     6'h13
`define CPU_OP_B        6'h14
`define CPU_OP_BL       6'h15
`define CPU_OP_BEQ      6'h16
`define CPU_OP_BNE      6'h17

// 1ri20 format keeps the opcode in inst[31:25].
`define CPU_OP_LU12I_W  7'h0a

`endif
